/* decomp_subsystem.f */
design/decomp_pkg.sv
design/comp_line_buffer.sv
design/page_decompressor.sv
design/out_line_fifo.sv
design/decomp_subsystem.sv
tb/decomp_assert.sv
tb/decomp_checker.sv
tb/tb_decomp_subsystem.sv

/* design/comp_line_buffer.sv */
module comp_line_buffer
	import decomp_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int PTR_W  = 7
) (
	input  logic              clk_i,
	input  logic              rst_ni,

	input  logic              load_we,
	input  logic              load_clr,
	input  logic [DATA_W-1:0] load_data,
	input  logic              load_err,

	input  logic              rd_req,
	input  logic [PTR_W-1:0]  rdfifo_rdptr,
	input  logic              ld_rdfifo_rdptr,

	output logic              rd_valid,
	output logic [DATA_W-1:0] rd_data,
	output rresp_e            rd_rresp,
	output logic              rdfifo_empty
);

	localparam int DEPTH = 2 ** PTR_W;

	logic [DATA_W-1:0] line_mem [DEPTH];
	logic              err_flag [DEPTH];  // lines the loader marked bad

	logic [PTR_W-1:0] wr_cnt;
	logic [PTR_W-1:0] rd_ptr;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_cnt <= '0;
		end else if (load_clr) begin
			wr_cnt <= '0;
		end else if (load_we) begin
			wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_we && !load_clr) begin
			line_mem[wr_cnt] <= load_data;
			err_flag[wr_cnt] <= load_err;
		end
	end

	// a pointer load wins over the increment of a read
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_ptr <= '0;
		end else if (load_clr) begin
			rd_ptr <= '0;
		end else if (ld_rdfifo_rdptr) begin
			rd_ptr <= rdfifo_rdptr;
		end else if (rd_req) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_req;  // answer exactly one cycle later
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_req) begin
			rd_data  <= line_mem[rd_ptr];
			rd_rresp <= err_flag[rd_ptr] ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign rdfifo_empty = (rd_ptr == wr_cnt);

endmodule

/* design/decomp_pkg.sv */
package decomp_pkg;

	// page geometry
	localparam int CHUNKS          = 4;
	localparam int LINES_PER_CHUNK = 16;

	// page decompressor states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		METADATA   = 3'd1,  // read the zero-chunk vector
		EXPAND     = 3'd2,  // pick the next chunk
		FILL_ZEROS = 3'd3,
		LD_RDPTR   = 3'd4,  // point the buffer at the chunk's first stored line
		COPY_LINES = 3'd5,
		DONE       = 3'd6,
		BUS_ERROR  = 3'd7
	} decomp_state_e;

	// read response, same encoding as an AXI RRESP
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} rresp_e;

endpackage

/* design/decomp_subsystem.sv */
module decomp_subsystem
	import decomp_pkg::*;
#(
	parameter int DATA_W         = 32,
	parameter int PTR_W          = 7,
	parameter int FIFO_DEPTH_LOG = 3
) (
	input  logic              clk_i,
	input  logic              rst_ni,

	input  logic              load_we,
	input  logic              load_clr,
	input  logic [DATA_W-1:0] load_data,
	input  logic              load_err,

	input  logic              decomp_start,
	input  logic              out_pop,

	output logic [DATA_W-1:0] out_data,
	output logic              out_empty,
	output logic              decomp_done,
	output logic              bus_error
);

	// buffer read side
	logic              rd_req;
	logic              rd_valid;
	logic [DATA_W-1:0] rd_data;
	rresp_e            rd_rresp;
	logic              rdfifo_empty;
	logic [PTR_W-1:0]  rdfifo_rdptr;
	logic              ld_rdfifo_rdptr;

	// output FIFO write side
	logic              wr_req;
	logic [DATA_W-1:0] wr_data;
	logic              wrfifo_full;

	comp_line_buffer #(
		.DATA_W (DATA_W),
		.PTR_W  (PTR_W)
	) u_comp_line_buffer (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.load_we         (load_we),
		.load_clr        (load_clr),
		.load_data       (load_data),
		.load_err        (load_err),
		.rd_req          (rd_req),
		.rdfifo_rdptr    (rdfifo_rdptr),
		.ld_rdfifo_rdptr (ld_rdfifo_rdptr),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.rd_rresp        (rd_rresp),
		.rdfifo_empty    (rdfifo_empty)
	);

	page_decompressor #(
		.DATA_W (DATA_W),
		.PTR_W  (PTR_W)
	) u_page_decompressor (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.decomp_start    (decomp_start),
		.rdfifo_empty    (rdfifo_empty),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.rd_rresp        (rd_rresp),
		.rd_req          (rd_req),
		.rdfifo_rdptr    (rdfifo_rdptr),
		.ld_rdfifo_rdptr (ld_rdfifo_rdptr),
		.wrfifo_full     (wrfifo_full),
		.wr_req          (wr_req),
		.wr_data         (wr_data),
		.decomp_done     (decomp_done),
		.bus_error       (bus_error)
	);

	out_line_fifo #(
		.DATA_W         (DATA_W),
		.FIFO_DEPTH_LOG (FIFO_DEPTH_LOG)
	) u_out_line_fifo (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.wr_req      (wr_req),
		.wr_data     (wr_data),
		.wrfifo_full (wrfifo_full),
		.out_pop     (out_pop),
		.out_empty   (out_empty),
		.out_data    (out_data)
	);

endmodule

/* design/out_line_fifo.sv */
module out_line_fifo #(
	parameter int DATA_W         = 32,
	parameter int FIFO_DEPTH_LOG = 3
) (
	input  logic              clk_i,
	input  logic              rst_ni,

	input  logic              wr_req,
	input  logic [DATA_W-1:0] wr_data,
	output logic              wrfifo_full,

	input  logic              out_pop,
	output logic              out_empty,
	output logic [DATA_W-1:0] out_data
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG;

	logic [DATA_W-1:0] fifo_mem [DEPTH];

	// one extra bit tells full from empty
	logic [FIFO_DEPTH_LOG:0] wr_ptr;
	logic [FIFO_DEPTH_LOG:0] rd_ptr;

	logic do_push;
	logic do_pop;

	assign wrfifo_full = (wr_ptr[FIFO_DEPTH_LOG] != rd_ptr[FIFO_DEPTH_LOG]) &&
		(wr_ptr[FIFO_DEPTH_LOG-1:0] == rd_ptr[FIFO_DEPTH_LOG-1:0]);
	assign out_empty = (wr_ptr == rd_ptr);

	assign do_push = wr_req && !wrfifo_full;
	assign do_pop  = out_pop && !out_empty;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			fifo_mem[wr_ptr[FIFO_DEPTH_LOG-1:0]] <= wr_data;
		end
	end

	assign out_data = fifo_mem[rd_ptr[FIFO_DEPTH_LOG-1:0]];  // head word, fall-through

endmodule

/* design/page_decompressor.sv */
module page_decompressor
	import decomp_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int PTR_W  = 7
) (
	input  logic              clk_i,
	input  logic              rst_ni,

	input  logic              decomp_start,

	input  logic              rdfifo_empty,
	input  logic              rd_valid,
	input  logic [DATA_W-1:0] rd_data,
	input  rresp_e            rd_rresp,
	output logic              rd_req,
	output logic [PTR_W-1:0]  rdfifo_rdptr,
	output logic              ld_rdfifo_rdptr,

	input  logic              wrfifo_full,
	output logic              wr_req,
	output logic [DATA_W-1:0] wr_data,

	output logic              decomp_done,
	output logic              bus_error
);

	localparam int         CIDX_W    = $clog2(CHUNKS);
	localparam logic [4:0] LAST_LINE = 5'(LINES_PER_CHUNK - 1);
	localparam logic [4:0] FULL_CNT  = 5'(LINES_PER_CHUNK);

	decomp_state_e state, n_state;

	logic [CHUNKS-1:0] zero_chunk_vec, n_zero_chunk_vec;
	logic [CHUNKS-1:0] chunk_done, n_chunk_done;
	logic [CIDX_W-1:0] cur_chunk, n_cur_chunk;
	logic [CIDX_W:0]   data_cnt, n_data_cnt;  // data chunks already copied
	logic [4:0]        line_cnt, n_line_cnt;
	logic              n_rd_req;

	// a line that came back while the output FIFO was full
	logic              hold_v, n_hold_v;
	logic [DATA_W-1:0] hold_data;

	logic copy_in;
	logic fill_in;
	logic rd_err;
	logic push;
	logic last_chunk;

	assign copy_in    = (state == COPY_LINES) && rd_valid && (rd_rresp == RESP_OKAY);
	assign rd_err     = rd_valid && (rd_rresp == RESP_SLVERR);
	assign fill_in    = (state == FILL_ZEROS);
	assign push       = !wrfifo_full && (hold_v || copy_in || fill_in);
	assign last_chunk = &(chunk_done | (CHUNKS'(1) << cur_chunk));

	assign wr_req  = push;
	assign wr_data = hold_v ? hold_data : (copy_in ? rd_data : '0);

	// chunk n of the page starts behind the metadata line and the earlier data chunks
	assign ld_rdfifo_rdptr = (state == LD_RDPTR);
	assign rdfifo_rdptr    = PTR_W'(data_cnt * LINES_PER_CHUNK + 1);

	assign decomp_done = (state == DONE);
	assign bus_error   = (state == BUS_ERROR);

	always_comb begin
		n_state          = state;
		n_zero_chunk_vec = zero_chunk_vec;
		n_chunk_done     = chunk_done;
		n_cur_chunk      = cur_chunk;
		n_data_cnt       = data_cnt;
		n_line_cnt       = line_cnt;
		n_hold_v         = hold_v;
		n_rd_req         = 1'b0;

		case (state)
			IDLE: begin
				if (decomp_start && !rdfifo_empty) begin
					n_state      = METADATA;
					n_chunk_done = '0;
					n_data_cnt   = '0;
				end
			end
			METADATA: begin
				n_rd_req = !rd_req && !rd_valid && !rdfifo_empty;  // one read only
				if (rd_valid) begin
					if (rd_err) begin
						n_state = BUS_ERROR;
					end else begin
						n_zero_chunk_vec = rd_data[CHUNKS-1:0];
						n_state          = EXPAND;
					end
				end
			end
			EXPAND: begin
				n_line_cnt = '0;
				// lowest chunk not yet expanded
				for (int i = CHUNKS - 1; i >= 0; i--) begin
					if (!chunk_done[i]) begin
						n_cur_chunk = CIDX_W'(i);
					end
				end
				n_state = zero_chunk_vec[n_cur_chunk] ? FILL_ZEROS : LD_RDPTR;
			end
			FILL_ZEROS: begin
				if (push) begin
					n_line_cnt = line_cnt + 5'd1;
					if (line_cnt == LAST_LINE) begin
						n_chunk_done[cur_chunk] = 1'b1;
						n_state = last_chunk ? DONE : EXPAND;
					end
				end
			end
			LD_RDPTR: begin
				n_rd_req = !wrfifo_full;  // first line of the chunk right after the load
				n_state  = COPY_LINES;
			end
			COPY_LINES: begin
				if (rd_err) begin
					n_state = BUS_ERROR;
				end else begin
					if (copy_in) begin
						n_line_cnt = line_cnt + 5'd1;
						n_hold_v   = wrfifo_full;
					end else if (push) begin
						n_hold_v = 1'b0;  // held line went out
					end
					// next read only once the returning line is sure to have a place
					n_rd_req = !rd_req && !n_hold_v && !wrfifo_full && !rdfifo_empty &&
						(n_line_cnt < FULL_CNT);
					if (n_line_cnt == FULL_CNT && !n_hold_v) begin
						n_chunk_done[cur_chunk] = 1'b1;
						n_data_cnt = data_cnt + 1'b1;
						n_state    = last_chunk ? DONE : EXPAND;
					end
				end
			end
			DONE: begin
				if (!decomp_start) begin
					n_state = IDLE;
				end
			end
			BUS_ERROR: begin
				n_state = BUS_ERROR;  // left by reset only
			end
			default: begin
				n_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state          <= IDLE;
			zero_chunk_vec <= '0;
			chunk_done     <= '0;
			cur_chunk      <= '0;
			data_cnt       <= '0;
			line_cnt       <= '0;
			hold_v         <= 1'b0;
			rd_req         <= 1'b0;
		end else begin
			state          <= n_state;
			zero_chunk_vec <= n_zero_chunk_vec;
			chunk_done     <= n_chunk_done;
			cur_chunk      <= n_cur_chunk;
			data_cnt       <= n_data_cnt;
			line_cnt       <= n_line_cnt;
			hold_v         <= n_hold_v;
			rd_req         <= n_rd_req;
		end
	end

	always_ff @(posedge clk_i) begin
		if (copy_in && wrfifo_full) begin
			hold_data <= rd_data;
		end
	end

endmodule

/* tb/decomp_assert.sv */
module decomp_assert (
	input logic clk_i,
	input logic rst_ni,
	input logic rd_req,
	input logic rd_valid,
	input logic wr_req,
	input logic wrfifo_full,
	input logic bus_error
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;  // assertion failures seen so far

	no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(wr_req && wrfifo_full))
	else begin
		fail_cnt++;
		$error("wr_req raised while the output FIFO is full");
	end

	// the response cycle carries no new request
	one_read_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rd_req |=> (rd_valid && !rd_req))
	else begin
		fail_cnt++;
		$error("rd_req raised in the cycle of the expected rd_valid");
	end

	bus_error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
	else begin
		fail_cnt++;
		$error("bus_error fell without a reset");
	end

endmodule

/* tb/decomp_checker.sv */
module decomp_checker (
	input  logic         clk_i,
	input  logic         test_begin,
	input  logic         test_end,
	input  logic [127:0] test_name,
	input  logic [3:0]   zero_vec,
	input  logic [31:0]  data_seed,
	input  int           err_idx,
	input  logic         decomp_start,
	input  logic         out_pop,
	input  logic         out_empty,
	input  logic [31:0]  out_data,
	input  logic         decomp_done,
	input  logic         bus_error,
	output int           ok_cnt,
	output int           bad_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] LCG_SEED = 32'h989020b3;

	logic [31:0] exp_q [$];
	logic        active = 1'b0;
	logic        err_exp;
	logic        seen_done;
	logic        seen_err;
	logic        start_q;
	logic        done_q;
	int          pop_cnt;
	int          errs;

	initial begin
		ok_cnt  = 0;
		bad_cnt = 0;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// page in chunk order, cut off before the first bad line
	task automatic build_expected();
		logic [31:0] st;
		int          ld;
		exp_q.delete();
		st      = LCG_SEED ^ data_seed;
		ld      = 0;
		err_exp = (err_idx == 0);
		for (int c = 0; c < 4; c++) begin
			for (int j = 0; j < 16; j++) begin
				if (zero_vec[c]) begin
					if (!err_exp) exp_q.push_back(32'h0);
				end else begin
					ld++;
					st = lcg_next(st);
					if (ld == err_idx) err_exp = 1'b1;
					if (!err_exp) exp_q.push_back(st);
				end
			end
		end
	endtask

	task automatic check_word();
		if (pop_cnt >= exp_q.size()) begin
			$display("%0s: extra word %h popped after %0d words", test_name, out_data, pop_cnt);
			errs++;
		end else if (out_data !== exp_q[pop_cnt]) begin
			$display("[FAIL] %0s word %0d: expected %h, actual %h", test_name, pop_cnt,
				exp_q[pop_cnt], out_data);
			errs++;
		end
		pop_cnt++;
	endtask

	task automatic finish_test();
		if (pop_cnt != exp_q.size()) begin
			$display("%0s: popped %0d words, expected %0d", test_name, pop_cnt, exp_q.size());
			errs++;
		end
		if (err_exp && (!seen_err || seen_done)) begin
			$display("%0s: expected bus_error without done, saw bus_error %0b done %0b",
				test_name, seen_err, seen_done);
			errs++;
		end
		if (!err_exp && (!seen_done || seen_err)) begin
			$display("%0s: expected done without bus_error, saw done %0b bus_error %0b",
				test_name, seen_done, seen_err);
			errs++;
		end
		if (errs == 0) begin
			ok_cnt++;
			$display("%0s: ok, %0d words", test_name, pop_cnt);
		end else begin
			bad_cnt++;
			$display("%0s: %0d errors", test_name, errs);
		end
		active = 1'b0;
	endtask

	always @(posedge clk_i) begin
		if (test_begin) begin
			build_expected();
			pop_cnt   = 0;
			errs      = 0;
			seen_done = 1'b0;
			seen_err  = 1'b0;
			start_q   = 1'b0;
			done_q    = 1'b0;
			active    = 1'b1;
		end else if (active) begin
			if (out_pop && !out_empty) check_word();
			if (decomp_done) seen_done = 1'b1;
			if (bus_error) seen_err = 1'b1;
			if (done_q && !decomp_done && start_q) begin
				$display("%0s: done fell while decomp_start was still high", test_name);
				errs++;
			end
			if (decomp_done && !start_q) begin  // one cycle of grace after start drops
				$display("%0s: done still high after decomp_start dropped", test_name);
				errs++;
			end
			start_q = decomp_start;
			done_q  = decomp_done;
			if (test_end) finish_test();
		end
	end

endmodule

/* tb/decomp_vectors.txt */
# name  zero_vec(bit 0 = chunk 0, written last)  err_idx(load index, 0 = metadata, -1 none)
# seed(hex)  pop_pattern(hex, bit n pops in cycle n mod 32)  reset_before(1/0)
all_zero    1111  -1  00000000  ffffffff  1
all_data    0000  -1  0000a5a5  ffffffff  1
mix_0101    0101  -1  00001234  ffffffff  1
mix_1001    1001  -1  0000beef  ffffffff  1
mix_0110    0110  -1  00c0ffee  aaaaaaaa  1
sparse_pop  0010  -1  13572468  01010101  1
sparse_zero 1101  -1  0badf00d  00000101  1
second_pg   1010  -1  00005555  ffffffff  0
third_pg    0011  -1  00006666  33333333  0
meta_err    0000   0  00000042  ffffffff  1
data_err    0100  20  00000777  ffffffff  1
late_err    0000  60  00099999  11111111  1

/* tb/tb_decomp_subsystem.sv */
module tb_decomp_subsystem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam string       VEC_FILE  = "tb/decomp_vectors.txt";
	localparam int          MAX_TESTS = 32;
	localparam logic [31:0] LCG_SEED  = 32'h989020b3;

	logic        clk_i = 1'b0;
	logic        rst_ni = 1'b0;
	logic        load_we = 1'b0;
	logic        load_clr = 1'b0;
	logic [31:0] load_data = '0;
	logic        load_err = 1'b0;
	logic        decomp_start = 1'b0;
	logic        out_pop = 1'b0;
	logic [31:0] out_data;
	logic        out_empty;
	logic        decomp_done;
	logic        bus_error;

	logic [127:0] t_name [MAX_TESTS];
	logic [3:0]   t_vec [MAX_TESTS];
	int           t_err [MAX_TESTS];
	logic [31:0]  t_seed [MAX_TESTS];
	logic [31:0]  t_pat [MAX_TESTS];
	int           t_rst [MAX_TESTS];
	int           num_tests = 0;

	logic [127:0] cur_name = '0;
	logic [3:0]   cur_vec = '0;
	logic [31:0]  cur_seed = '0;
	int           cur_err = -1;
	logic         test_begin = 1'b0;
	logic         test_end = 1'b0;
	int           ok_cnt;
	int           bad_cnt;
	int           assert_fails;
	int           cycle_cnt = 0;
	int           cycle_limit = 400 * 65;

	always #20 clk_i = ~clk_i;

	decomp_subsystem #(
		.DATA_W         (32),
		.PTR_W          (7),
		.FIFO_DEPTH_LOG (3)
	) u_decomp_subsystem (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.load_we      (load_we),
		.load_clr     (load_clr),
		.load_data    (load_data),
		.load_err     (load_err),
		.decomp_start (decomp_start),
		.out_pop      (out_pop),
		.out_data     (out_data),
		.out_empty    (out_empty),
		.decomp_done  (decomp_done),
		.bus_error    (bus_error)
	);

	decomp_checker u_decomp_checker (
		.clk_i        (clk_i),
		.test_begin   (test_begin),
		.test_end     (test_end),
		.test_name    (cur_name),
		.zero_vec     (cur_vec),
		.data_seed    (cur_seed),
		.err_idx      (cur_err),
		.decomp_start (decomp_start),
		.out_pop      (out_pop),
		.out_empty    (out_empty),
		.out_data     (out_data),
		.decomp_done  (decomp_done),
		.bus_error    (bus_error),
		.ok_cnt       (ok_cnt),
		.bad_cnt      (bad_cnt)
	);

	bind page_decompressor decomp_assert u_decomp_assert (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.rd_req      (rd_req),
		.rd_valid    (rd_valid),
		.wr_req      (wr_req),
		.wrfifo_full (wrfifo_full),
		.bus_error   (bus_error)
	);

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic step();  // next drive point, 2 ns after the rising edge
		@(posedge clk_i);
		#2;
	endtask

	task automatic read_vectors();
		int    fd;
		int    n;
		string line;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", VEC_FILE);
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = "";
				n    = $fgets(line, fd);
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %b %d %h %h %d", t_name[num_tests], t_vec[num_tests],
						t_err[num_tests], t_seed[num_tests], t_pat[num_tests], t_rst[num_tests]);
					if (n == 6) num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		rst_ni = 1'b0;
		repeat (3) step();
		rst_ni = 1'b1;
	endtask

	task automatic load_line(input logic [31:0] data, input logic err);
		load_we   = 1'b1;
		load_data = data;
		load_err  = err;
		step();
		load_we  = 1'b0;
		load_err = 1'b0;
	endtask

	task automatic run_test(input int t);
		logic [31:0] st;
		int          ld;
		int          cyc;
		cur_name = t_name[t];
		cur_vec  = t_vec[t];
		cur_seed = t_seed[t];
		cur_err  = t_err[t];
		if (t_rst[t] != 0 || t == 0) apply_reset();
		load_clr = 1'b1;
		step();
		load_clr = 1'b0;
		load_line({cur_seed[27:0], cur_vec}, cur_err == 0);  // metadata line
		st = LCG_SEED ^ cur_seed;
		ld = 0;
		for (int c = 0; c < 4; c++) begin
			if (!cur_vec[c]) begin
				for (int j = 0; j < 16; j++) begin
					ld++;
					st = lcg_next(st);
					load_line(st, ld == cur_err);
				end
			end
		end
		test_begin = 1'b1;
		step();
		test_begin   = 1'b0;
		decomp_start = 1'b1;
		cyc = 0;
		while (!((decomp_done || bus_error) && out_empty)) begin
			out_pop = !out_empty && t_pat[t][cyc % 32];
			step();
			cyc++;
		end
		out_pop = 1'b0;
		if (!bus_error) repeat (4) step();  // done must hold while start stays high
		decomp_start = 1'b0;
		repeat (3) step();
		test_end = 1'b1;
		step();
		test_end = 1'b0;
	endtask

	initial begin
		read_vectors();
		cycle_limit = 400 * 65 * (num_tests > 0 ? num_tests : 1);
		if (num_tests == 0) begin
			$display("no usable vectors in %s", VEC_FILE);
			$display("test failed");
			$finish;
		end else begin
			for (int t = 0; t < num_tests; t++) begin
				run_test(t);
			end
			assert_fails = u_decomp_subsystem.u_page_decompressor.u_decomp_assert.fail_cnt;
			$display("%0d tests: %0d ok, %0d with errors, %0d assertion failures",
				num_tests, ok_cnt, bad_cnt, assert_fails);
			if (bad_cnt == 0 && assert_fails == 0 && ok_cnt == num_tests) begin
				$display("test passed");
			end else begin
				$display("test failed");
			end
			$finish;
		end
	end

endmodule
